// File: source/soc_bus_cfg.svh
`ifndef SOC_BUS_CFG_SVH
`define SOC_BUS_CFG_SVH

//////////////////////////////
// Bus widths
//////////////////////////////
`define SOC_ADDR_WIDTH 32
`define SOC_DATA_WIDTH 32
// One enable per data byte
`define SOC_BE_WIDTH 4

//////////////////////////////
// Memory map
//////////////////////////////
// Bank depth in words, must cover SOC_REGION_BYTES
`define SOC_BANK_WORDS 256
`define SOC_INST_BASE 32'h0000_0000
`define SOC_DATA_BASE 32'h0001_0000
// Region size, bases aligned to it
`define SOC_REGION_BYTES 1024

`endif

// File: source/soc_bus_pkg.sv
`include "soc_bus_cfg.svh"

package soc_bus_pkg;

    // Core side and held request share one layout
    typedef struct packed {
        logic                          req;
        logic                          we;
        logic [`SOC_BE_WIDTH-1:0]      be;
        logic [`SOC_ADDR_WIDTH-1:0]    addr;
        logic [`SOC_DATA_WIDTH-1:0]    wdata;
    } mem_req_t;

    // One response per accepted request
    typedef struct packed {
        logic                          rvalid;
        // Decode miss only
        logic                          err;
        logic [`SOC_DATA_WIDTH-1:0]    rdata;
    } mem_rsp_t;

    // Holding register states
    typedef enum logic [1:0] {
        HOLD_IDLE  = 2'd0,
        // Request on the bus, waiting for a grant
        HOLD_ISSUE = 2'd1,
        // Granted, waiting for rvalid
        HOLD_WAIT  = 2'd2
    } hold_state_e;

endpackage

// File: source/soc_map_pkg.sv
`include "soc_bus_cfg.svh"

package soc_map_pkg;

    // Slave regions, also the bank index
    typedef enum logic [0:0] {
        REGION_INST = 1'b0,
        REGION_DATA = 1'b1
    } region_e;

    localparam int unsigned REGION_COUNT = 2;

    // Half-open range, end_addr is the first byte past the region
    typedef struct packed {
        logic [`SOC_ADDR_WIDTH-1:0] start_addr;
        logic [`SOC_ADDR_WIDTH-1:0] end_addr;
    } addr_rule_t;

    //////////////////////////////
    // Rule table
    //////////////////////////////
    // Entries in region_e order
    localparam addr_rule_t ADDR_MAP [REGION_COUNT] = '{
        '{start_addr: (`SOC_INST_BASE),
          end_addr:   (`SOC_INST_BASE) + (`SOC_REGION_BYTES)},
        '{start_addr: (`SOC_DATA_BASE),
          end_addr:   (`SOC_DATA_BASE) + (`SOC_REGION_BYTES)}
    };

endpackage

// File: source/core_req_hold.sv
`timescale 1ns/1ps

module core_req_hold (
    input  logic                   clk_i,
    input  logic                   reset_i,
    // Core side
    input  soc_bus_pkg::mem_req_t  core_req_i,
    output logic                   gnt_o,
    // Bus side
    output soc_bus_pkg::mem_req_t  bus_req_o,
    input  logic                   bus_gnt_i,
    input  logic                   rsp_valid_i
);
    import soc_bus_pkg::*;

    hold_state_e state_q;
    // Copy of the accepted request
    mem_req_t    hold_q;
    logic        accept;

    // Core is granted only with nothing outstanding
    assign gnt_o  = (state_q == HOLD_IDLE);
    assign accept = core_req_i.req & gnt_o;

    //////////////////////////////
    // State register
    //////////////////////////////
    always_ff @(posedge clk_i, posedge reset_i) begin
        if (reset_i) begin
            state_q <= HOLD_IDLE;
        end else begin
            case (state_q)
                HOLD_IDLE:  if (accept) state_q <= HOLD_ISSUE;
                // Replayed until some slave or the miss path grants
                HOLD_ISSUE: if (bus_gnt_i) state_q <= HOLD_WAIT;
                HOLD_WAIT:  if (rsp_valid_i) state_q <= HOLD_IDLE;
                default:    state_q <= HOLD_IDLE;
            endcase
        end
    end

    // Payload capture on accept
    always_ff @(posedge clk_i) begin
        if (accept) begin
            hold_q <= core_req_i;
        end
    end

    // Held fields always visible, strobe only while issuing
    always_comb begin
        bus_req_o     = hold_q;
        bus_req_o.req = (state_q == HOLD_ISSUE);
    end

    //////////////////////////////
    // Checks
    //////////////////////////////
    // Responses arrive only after the grant
    a_rsp_in_wait: assert property (@(posedge clk_i) disable iff (reset_i)
        rsp_valid_i |-> state_q == HOLD_WAIT);

    // Ungranted request is replayed unchanged
    a_issue_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        (state_q == HOLD_ISSUE) && !bus_gnt_i |=> $stable(bus_req_o));

endmodule

// File: source/bus_addr_decoder.sv
`timescale 1ns/1ps

module bus_addr_decoder (
    input  soc_bus_pkg::mem_req_t                  bus_req_i,
    output logic [soc_map_pkg::REGION_COUNT-1:0]   bank_sel_o,
    output logic                                   miss_o
);
    import soc_map_pkg::*;

    // Per-rule address hit
    logic [REGION_COUNT-1:0] hit;

    //////////////////////////////
    // Range compare
    //////////////////////////////
    always_comb begin
        for (int r = 0; r < REGION_COUNT; r++) begin
            hit[r] = (bus_req_i.addr >= ADDR_MAP[r].start_addr) &&
                     (bus_req_i.addr <  ADDR_MAP[r].end_addr);
        end
    end

    // Selects only for a live request
    always_comb begin
        bank_sel_o = '0;
        if (bus_req_i.req) begin
            bank_sel_o = hit;
        end
    end

    // No rule matched, error path takes it
    assign miss_o = bus_req_i.req && (hit == '0);

    //////////////////////////////
    // Checks
    //////////////////////////////
    // Rule table must not overlap
    always_comb begin
        a_sel_onehot: assert ($onehot0(bank_sel_o))
            else $error("bus_addr_decoder: overlapping regions selected");
    end

endmodule

// File: source/sram_bank.sv
`timescale 1ns/1ps

`include "soc_bus_cfg.svh"

module sram_bank (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   sel_i,
    input  soc_bus_pkg::mem_req_t  bus_req_i,
    output logic                   gnt_o,
    output soc_bus_pkg::mem_rsp_t  rsp_o
);
    localparam int unsigned BYTE_W   = `SOC_DATA_WIDTH / `SOC_BE_WIDTH;
    localparam int unsigned IDX_W    = $clog2(`SOC_BANK_WORDS);
    localparam int unsigned BYTE_OFS = $clog2(`SOC_BE_WIDTH);

    logic [`SOC_DATA_WIDTH-1:0] mem_q [`SOC_BANK_WORDS];
    logic [IDX_W-1:0]           word_idx;
    logic                       rvalid_q;
    logic [`SOC_DATA_WIDTH-1:0] rdata_q;

    // Word offset, regions sit on bank-size boundaries
    assign word_idx = bus_req_i.addr[IDX_W+BYTE_OFS-1:BYTE_OFS];

    // Always ready when selected
    assign gnt_o = sel_i;

    //////////////////////////////
    // Array access
    //////////////////////////////
    always_ff @(posedge clk_i) begin
        if (sel_i) begin
            if (bus_req_i.we) begin
                // Enabled lanes only
                for (int b = 0; b < `SOC_BE_WIDTH; b++) begin
                    if (bus_req_i.be[b]) begin
                        mem_q[word_idx][b*BYTE_W +: BYTE_W] <= bus_req_i.wdata[b*BYTE_W +: BYTE_W];
                    end
                end
            end else begin
                rdata_q <= mem_q[word_idx];
            end
        end
    end

    // One-cycle response strobe, writes too
    always_ff @(posedge clk_i, posedge reset_i) begin
        if (reset_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= sel_i;
        end
    end

    assign rsp_o = '{rvalid: rvalid_q, err: 1'b0, rdata: rdata_q};

endmodule

// File: source/bus_resp_mux.sv
`timescale 1ns/1ps

module bus_resp_mux (
    input  logic                                                    clk_i,
    input  logic                                                    reset_i,
    input  logic [soc_map_pkg::REGION_COUNT-1:0]                    bank_gnt_i,
    input  soc_bus_pkg::mem_rsp_t [soc_map_pkg::REGION_COUNT-1:0]   bank_rsp_i,
    input  logic                                                    miss_i,
    output logic                                                    bus_gnt_o,
    output soc_bus_pkg::mem_rsp_t                                   rsp_o
);
    import soc_map_pkg::*;

    // Error response pending for the next cycle
    logic                    miss_q;
    // One bit per response source
    logic [REGION_COUNT:0]   src_valid;

    // Miss is granted here, no slave sees it
    assign bus_gnt_o = (|bank_gnt_i) | miss_i;

    always_ff @(posedge clk_i, posedge reset_i) begin
        if (reset_i) begin
            miss_q <= 1'b0;
        end else begin
            miss_q <= miss_i;
        end
    end

    //////////////////////////////
    // Response select
    //////////////////////////////
    always_comb begin
        rsp_o = '0;
        for (int r = 0; r < REGION_COUNT; r++) begin
            src_valid[r] = bank_rsp_i[r].rvalid;
            if (bank_rsp_i[r].rvalid) begin
                rsp_o = bank_rsp_i[r];
            end
        end
        src_valid[REGION_COUNT] = miss_q;
        // Decode error, zero data
        if (miss_q) begin
            rsp_o.rvalid = 1'b1;
            rsp_o.err    = 1'b1;
            rsp_o.rdata  = '0;
        end
    end

    // Single outstanding request upstream
    a_one_source: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0(src_valid));

endmodule

// File: source/soc_bus_top.sv
`timescale 1ns/1ps

module soc_bus_top (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  soc_bus_pkg::mem_req_t  req_i,
    output logic                   gnt_o,
    output soc_bus_pkg::mem_rsp_t  rsp_o
);
    import soc_bus_pkg::*;
    import soc_map_pkg::*;

    //////////////////////////////
    // Internal bus
    //////////////////////////////
    mem_req_t                       bus_req;
    logic                           bus_gnt;
    logic [REGION_COUNT-1:0]        bank_sel;
    logic [REGION_COUNT-1:0]        bank_gnt;
    mem_rsp_t [REGION_COUNT-1:0]    bank_rsp;
    logic                           miss;

    // Request holding register
    core_req_hold i_hold (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .core_req_i  (req_i),
        .gnt_o       (gnt_o),
        .bus_req_o   (bus_req),
        .bus_gnt_i   (bus_gnt),
        .rsp_valid_i (rsp_o.rvalid)
    );

    bus_addr_decoder i_decoder (
        .bus_req_i  (bus_req),
        .bank_sel_o (bank_sel),
        .miss_o     (miss)
    );

    // One bank per region, in region_e order
    for (genvar r = 0; r < REGION_COUNT; r++) begin : g_bank
        sram_bank i_bank (
            .clk_i     (clk_i),
            .reset_i   (reset_i),
            .sel_i     (bank_sel[r]),
            .bus_req_i (bus_req),
            .gnt_o     (bank_gnt[r]),
            .rsp_o     (bank_rsp[r])
        );
    end

    bus_resp_mux i_resp_mux (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .bank_gnt_i (bank_gnt),
        .bank_rsp_i (bank_rsp),
        .miss_i     (miss),
        .bus_gnt_o  (bus_gnt),
        .rsp_o      (rsp_o)
    );

endmodule

// File: tb/tb_soc_bus.sv
`timescale 1ns/1ps

`include "soc_bus_cfg.svh"

module tb_soc_bus;
    import soc_bus_pkg::*;

    // Cycles allowed for any single wait
    localparam int unsigned WAIT_LIMIT = 20;

    logic        clk;
    logic        reset;
    mem_req_t    req;
    logic        gnt;
    mem_rsp_t    rsp;
    logic        accept;

    logic [31:0] lfsr;
    int unsigned err_count;
    int unsigned timeout_count;

    // One reference byte array per region
    logic [7:0]  model_mem [2][`SOC_REGION_BYTES];
    // Expected response of the outstanding request
    logic        exp_err;
    logic        exp_we;
    logic [31:0] exp_rdata;

    soc_bus_top i_dut (
        .clk_i   (clk),
        .reset_i (reset),
        .req_i   (req),
        .gnt_o   (gnt),
        .rsp_o   (rsp)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    assign accept = req.req && gnt;

    //////////////////////////////
    // Helpers
    //////////////////////////////
    // Galois LFSR for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // One step per bit taken
    function automatic logic [31:0] rand_bits(input int unsigned n);
        logic [31:0] v;
        v = '0;
        for (int unsigned i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    // Region index from the memory map or -1 outside both
    function automatic int region_of(input logic [31:0] addr);
        if (addr >= `SOC_INST_BASE && addr < `SOC_INST_BASE + `SOC_REGION_BYTES) begin
            return 0;
        end
        if (addr >= `SOC_DATA_BASE && addr < `SOC_DATA_BASE + `SOC_REGION_BYTES) begin
            return 1;
        end
        return -1;
    endfunction

    // Expected response from the model before its update
    always @(posedge clk) begin : model_update
        int r;
        int ofs;
        r   = region_of(req.addr);
        ofs = int'(req.addr[9:0] & 10'h3fc);
        if (accept) begin
            exp_we    <= req.we;
            exp_err   <= (r < 0);
            exp_rdata <= '0;
            if (r >= 0) begin
                exp_rdata <= {model_mem[r][ofs+3], model_mem[r][ofs+2],
                              model_mem[r][ofs+1], model_mem[r][ofs]};
                for (int b = 0; b < 4; b++) begin
                    if (req.we && req.be[b]) begin
                        model_mem[r][ofs+b] = req.wdata[b*8 +: 8];
                    end
                end
            end
        end
    end

    // One request with waits for grant and response
    task automatic access(input logic we, input logic [3:0] be,
                          input logic [31:0] addr, input logic [31:0] wdata);
        int unsigned n;
        n = 0;
        while (!gnt && n < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!gnt) begin
            timeout_count++;
            $display("Timeout at %0t: no grant for the next request", $time);
        end
        req = '{req: 1'b1, we: we, be: be, addr: addr, wdata: wdata};
        @(posedge clk);
        #1;
        req.req = 1'b0;
        n = 0;
        while (!rsp.rvalid && n < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!rsp.rvalid) begin
            timeout_count++;
            $display("Timeout at %0t: no response to address %h", $time, addr);
        end
        @(posedge clk);
        #1;
    endtask

    //////////////////////////////
    // Checks
    //////////////////////////////
    a_reset_state: assert property (@(posedge clk) reset |-> gnt && !rsp.rvalid)
        else begin
            err_count++;
            $display("Mismatch at %0t: gnt or rvalid wrong in reset", $time);
        end

    // Grant withheld and no response yet
    a_hold_after_accept: assert property (@(posedge clk) disable iff (reset)
        $past(accept) |-> !gnt && !rsp.rvalid)
        else begin
            err_count++;
            $display("Mismatch at %0t: early response or grant after accept", $time);
        end

    a_rsp_on_time: assert property (@(posedge clk) disable iff (reset)
        $past(accept, 2) |-> rsp.rvalid && !gnt)
        else begin
            err_count++;
            $display("Mismatch at %0t: rvalid missing 2 cycles after accept", $time);
        end

    // Exactly one response per accept
    a_no_extra_rsp: assert property (@(posedge clk) disable iff (reset)
        rsp.rvalid |-> $past(accept, 2))
        else begin
            err_count++;
            $display("Mismatch at %0t: rvalid without an accepted request", $time);
        end

    // Write data is not returned but miss data must be zero
    a_rsp_data: assert property (@(posedge clk) disable iff (reset)
        rsp.rvalid |-> rsp.err == exp_err &&
                       ((exp_we && !exp_err) || rsp.rdata == exp_rdata))
        else begin
            err_count++;
            $display("Mismatch at %0t: err %b rdata %h, expected err %b rdata %h",
                     $time, rsp.err, rsp.rdata, exp_err, exp_rdata);
        end

    //////////////////////////////
    // Stimulus
    //////////////////////////////
    initial begin
        logic [31:0] ofs;
        logic [31:0] data_a;
        logic [31:0] data_b;
        lfsr          = 32'h9436c063;
        err_count     = 0;
        timeout_count = 0;
        reset         = 1'b1;
        req           = '0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        assert (gnt && !rsp.rvalid)
            else begin
                err_count++;
                $display("Mismatch at %0t: not idle after reset", $time);
            end

        // Full words in the instruction region
        repeat (4) begin
            ofs    = rand_bits(8) << 2;
            data_a = rand_bits(32);
            access(1'b1, 4'hf, `SOC_INST_BASE + ofs, data_a);
            access(1'b0, 4'h0, `SOC_INST_BASE + ofs, 32'h0);
        end

        // Partial writes over a full word in both regions
        for (int r = 0; r < 4; r++) begin
            ofs = ((r % 2) ? `SOC_DATA_BASE : `SOC_INST_BASE) + (rand_bits(8) << 2);
            access(1'b1, 4'hf, ofs, rand_bits(32));
            access(1'b1, 4'(rand_bits(4)), ofs, rand_bits(32));
            access(1'b0, 4'h0, ofs, 32'h0);
        end

        // Same offset with different data per region
        ofs    = rand_bits(8) << 2;
        data_a = rand_bits(32);
        data_b = rand_bits(32);
        access(1'b1, 4'hf, `SOC_INST_BASE + ofs, data_a);
        access(1'b1, 4'hf, `SOC_DATA_BASE + ofs, data_b);
        access(1'b0, 4'h0, `SOC_INST_BASE + ofs, 32'h0);
        access(1'b0, 4'h0, `SOC_DATA_BASE + ofs, 32'h0);

        // Misses that alias the bank index of the word above
        access(1'b1, 4'hf, `SOC_INST_BASE + `SOC_REGION_BYTES + ofs, rand_bits(32));
        access(1'b1, 4'hf, `SOC_DATA_BASE + `SOC_REGION_BYTES + ofs, rand_bits(32));
        access(1'b0, 4'h0, 32'h0002_0000 + ofs, 32'h0);
        // Both regions untouched
        access(1'b0, 4'h0, `SOC_INST_BASE + ofs, 32'h0);
        access(1'b0, 4'h0, `SOC_DATA_BASE + ofs, 32'h0);

        repeat (2) @(posedge clk);
        $display("Errors: %0d mismatches, %0d timeouts", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+source
source/soc_bus_pkg.sv
source/soc_map_pkg.sv
source/core_req_hold.sv
source/bus_addr_decoder.sv
source/sram_bank.sv
source/bus_resp_mux.sv
source/soc_bus_top.sv
tb/tb_soc_bus.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_soc_bus -Mdir obj_dir -f list.f

./obj_dir/Vtb_soc_bus > sim.log 2>&1 || true
cat sim.log

# The log decides the result
if grep -q "All checks passed" sim.log; then
    exit 0
fi
echo "Simulation did not pass, see sim.log"
exit 1
